/* common/valu_pkg.sv */
// shared by every lane stage; the opcode and element-width codes are lane-internal, sew code 3 acts as 32 bits
`default_nettype none

package valu_pkg;

   localparam int unsigned VALU_XLEN    = 32;  // operand and result width
   localparam int unsigned VALU_PROD_W  = 64;  // full product width
   localparam int unsigned VALU_LATENCY = 4;   // strobe in to valid out, in clocks

   typedef enum logic [4:0] {
      ADD   = 5'd0,
      SUB   = 5'd1,
      AND   = 5'd2,
      OR    = 5'd3,
      XOR   = 5'd4,
      SLT   = 5'd5,   // set-on-compare group starts here
      SLTU  = 5'd6,
      SLE   = 5'd7,
      SLEU  = 5'd8,
      SGT   = 5'd9,
      SGTU  = 5'd10,
      SEQ   = 5'd11,
      SNE   = 5'd12,  // last compare
      MUL   = 5'd13,  // low half of product
      MULH  = 5'd14,  // signed high part
      MULHU = 5'd15   // unsigned high part
   } valu_op_e;

   typedef enum logic [1:0] {
      SEW8  = 2'd0,
      SEW16 = 2'd1,
      SEW32 = 2'd2
   } valu_sew_e;

   // signed treatment of operands, equality ops do not care
   function automatic logic valu_is_signed(input valu_op_e op);
      logic sgn;
      case (op)
         SLTU, SLEU, SGTU, SEQ, SNE, MULHU: sgn = 1'b0;  // zero-extended operands
         default:                           sgn = 1'b1;  // alu ops, signed compares, mul, mulh
      endcase
      return sgn;
   endfunction

   function automatic logic valu_is_compare(input valu_op_e op);
      logic cmp;
      case (op)
         SLT, SLTU, SLE, SLEU, SGT, SGTU, SEQ, SNE: cmp = 1'b1;
         default:                                   cmp = 1'b0;
      endcase
      return cmp;
   endfunction

   function automatic logic [5:0] valu_sew_bits(input valu_sew_e sew);
      logic [5:0] bits;
      case (sew)
         SEW8:    bits = 6'd8;
         SEW16:   bits = 6'd16;
         default: bits = 6'd32;  // SEW32 and the spare code
      endcase
      return bits;
   endfunction

endpackage : valu_pkg

`default_nettype wire

/* rtl/valu_operand_stage.sv */
// samples the operands on every clock whether or not an op is valid; only the low sew bits of each operand matter
`timescale 1ns/10ps
`default_nettype none

module valu_operand_stage
   import valu_pkg::*;
(
   input  wire logic                 clk,
   input  wire logic                 rstn,
   input  wire valu_op_e             op_i,
   input  wire valu_sew_e            sew_i,
   input  wire logic [VALU_XLEN-1:0] opa_i,
   input  wire logic [VALU_XLEN-1:0] opb_i,
   output valu_op_e                  op_o,
   output valu_sew_e                 sew_o,
   output logic [VALU_XLEN-1:0]      opa_ext_o,
   output logic [VALU_XLEN-1:0]      opb_ext_o
);

   valu_op_e             op_q;   // stage 1 opcode
   valu_sew_e            sew_q;  // stage 1 element width
   logic [VALU_XLEN-1:0] opa_q;  // raw operands, no reset
   logic [VALU_XLEN-1:0] opb_q;

   // pushes the element to the top, then shifts it back with or without sign fill
   function automatic logic [VALU_XLEN-1:0] sew_extend(input logic [VALU_XLEN-1:0] val,
                                                      input valu_sew_e            sew,
                                                      input logic                 sgn);
      logic [5:0]           pad;  // bits above the element
      logic [VALU_XLEN-1:0] top;  // element left-aligned
      logic [VALU_XLEN-1:0] ext;
      pad = 6'(VALU_XLEN - valu_sew_bits(sew));
      top = val << pad;
      if (sgn)
         ext = $signed(top) >>> pad;  // sign fill
      else
         ext = top >> pad;            // zero fill
      return ext;
   endfunction

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         op_q  <= ADD;
         sew_q <= SEW32;
      end
      else
      begin
         op_q  <= op_i;
         sew_q <= sew_i;
      end
   end

   always_ff @(posedge clk)
   begin
      opa_q <= opa_i;
      opb_q <= opb_i;
   end

   assign op_o      = op_q;
   assign sew_o     = sew_q;
   assign opa_ext_o = sew_extend(opa_q, sew_q, valu_is_signed(op_q));  // later stages see 32 bits only
   assign opb_ext_o = sew_extend(opb_q, sew_q, valu_is_signed(op_q));

endmodule : valu_operand_stage

`default_nettype wire

/* rtl/valu_compare.sv */
// expects operands already extended by the operand stage; non-compare opcodes give a zero flag
`timescale 1ns/10ps
`default_nettype none

module valu_compare
   import valu_pkg::*;
(
   input  wire logic                 clk,
   input  wire logic                 rstn,
   input  wire valu_op_e             op_i,
   input  wire logic [VALU_XLEN-1:0] opa_i,
   input  wire logic [VALU_XLEN-1:0] opb_i,
   output logic                      flag_o
);

   logic       lt;      // a below b under the opcode's signedness
   logic       eq;      // a equals b
   logic       flag_d;  // stage 1 result
   logic [1:0] flag_q;  // [0] at stage 2, [1] at stage 3

   always_comb
   begin
      if (valu_is_signed(op_i))
         lt = $signed(opa_i) < $signed(opb_i);
      else
         lt = opa_i < opb_i;
      eq = (opa_i == opb_i);
      case (op_i)
         SLT, SLTU: flag_d = lt;
         SLE, SLEU: flag_d = lt | eq;
         SGT, SGTU: flag_d = ~(lt | eq);  // strictly greater
         SEQ:       flag_d = eq;
         SNE:       flag_d = ~eq;
         default:   flag_d = 1'b0;        // arithmetic ops
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
         flag_q <= 2'b00;
      else
         flag_q <= {flag_q[0], flag_d};  // matches the two arith registers
   end

   assign flag_o = flag_q[1];

endmodule : valu_compare

`default_nettype wire

/* rtl/valu_arith.sv */
// operand register then result register, like a DSP slice; add and logic results sit in the low 32 bits
`timescale 1ns/10ps
`default_nettype none

module valu_arith
   import valu_pkg::*;
(
   input  wire logic                 clk,
   input  wire logic                 rstn,
   input  wire valu_op_e             op_i,
   input  wire logic [VALU_XLEN-1:0] opa_i,
   input  wire logic [VALU_XLEN-1:0] opb_i,
   output logic [VALU_PROD_W-1:0]    res_o,
   output valu_op_e                  op_o
);

   valu_op_e                    op_s2;   // opcode beside the operand register
   valu_op_e                    op_s3;   // opcode beside the result register
   logic [VALU_XLEN-1:0]        opa_s2;  // input register, a side
   logic [VALU_XLEN-1:0]        opb_s2;  // input register, b side
   logic signed [VALU_XLEN:0]   mul_a;   // one extra bit selects signed or unsigned
   logic signed [VALU_XLEN:0]   mul_b;
   logic signed [2*VALU_XLEN+1:0] prod; // 33x33 product, low 64 bits kept
   logic [VALU_PROD_W-1:0]      res_d;
   logic [VALU_PROD_W-1:0]      res_s3;  // product register

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         op_s2 <= ADD;
         op_s3 <= ADD;
      end
      else
      begin
         op_s2 <= op_i;
         op_s3 <= op_s2;
      end
   end

   always_ff @(posedge clk)
   begin
      opa_s2 <= opa_i;
      opb_s2 <= opb_i;
      res_s3 <= res_d;
   end

   // one multiplier serves mul, mulh and mulhu
   always_comb
   begin
      if (op_s2 == MULHU)
      begin
         mul_a = {1'b0, opa_s2};
         mul_b = {1'b0, opb_s2};
      end
      else
      begin
         mul_a = {opa_s2[VALU_XLEN-1], opa_s2};
         mul_b = {opb_s2[VALU_XLEN-1], opb_s2};
      end
      prod = mul_a * mul_b;
   end

   always_comb
   begin
      case (op_s2)
         ADD:             res_d = {{VALU_XLEN{1'b0}}, opa_s2 + opb_s2};  // carry dropped
         SUB:             res_d = {{VALU_XLEN{1'b0}}, opa_s2 - opb_s2};
         AND:             res_d = {{VALU_XLEN{1'b0}}, opa_s2 & opb_s2};
         OR:              res_d = {{VALU_XLEN{1'b0}}, opa_s2 | opb_s2};
         XOR:             res_d = {{VALU_XLEN{1'b0}}, opa_s2 ^ opb_s2};
         MUL, MULH, MULHU: res_d = prod[VALU_PROD_W-1:0];                 // full product
         default:         res_d = '0;  // compares take the flag path
      endcase
   end

   assign res_o = res_s3;
   assign op_o  = op_s3;

endmodule : valu_arith

`default_nettype wire

/* rtl/valu_result_stage.sv */
// result_o only changes on a load, so it holds the last result between strobes
`timescale 1ns/10ps
`default_nettype none

module valu_result_stage
   import valu_pkg::*;
(
   input  wire logic                   clk,
   input  wire logic                   rstn,
   input  wire logic                   load_i,
   input  wire valu_op_e               op_i,
   input  wire valu_sew_e              sew_i,
   input  wire logic [VALU_PROD_W-1:0] res_i,
   input  wire logic                   flag_i,
   output logic [VALU_XLEN-1:0]        result_o
);

   logic [VALU_PROD_W-1:0] res_hi;    // product moved down by the element width
   logic [VALU_XLEN-1:0]   result_d;  // value to load

   always_comb
   begin
      res_hi = res_i >> valu_sew_bits(sew_i);
      if (valu_is_compare(op_i))
         result_d = {{(VALU_XLEN-1){1'b0}}, flag_i};  // 0 or 1
      else if (op_i == MULH || op_i == MULHU)
         result_d = res_hi[VALU_XLEN-1:0];            // upper element half, extended
      else
         result_d = res_i[VALU_XLEN-1:0];             // alu result or mul low part
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
         result_o <= '0;
      else if (load_i)
         result_o <= result_d;
   end

endmodule : valu_result_stage

`default_nettype wire

/* rtl/valu_lane.sv */
// no back-pressure, a result is lost unless taken on its valid_o cycle; up to four ops in flight
`timescale 1ns/10ps
`default_nettype none

module valu_lane
   import valu_pkg::*;
(
   input  wire logic                 clk,
   input  wire logic                 rstn,
   input  wire logic                 valid_i,
   input  wire valu_op_e             op_i,
   input  wire valu_sew_e            sew_i,
   input  wire logic [VALU_XLEN-1:0] opa_i,
   input  wire logic [VALU_XLEN-1:0] opb_i,
   output logic                      valid_o,
   output logic [VALU_XLEN-1:0]      result_o
);

   logic [VALU_LATENCY:1]  vld_q;   // bit n marks a live op at stage n
   valu_op_e               s1_op;
   valu_sew_e              s1_sew;
   valu_sew_e              s2_sew;  // element width follows the op down
   valu_sew_e              s3_sew;
   logic [VALU_XLEN-1:0]   s1_opa;  // extended operands
   logic [VALU_XLEN-1:0]   s1_opb;
   valu_op_e               s3_op;
   logic [VALU_PROD_W-1:0] s3_res;
   logic                   s3_flag;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         vld_q  <= '0;
         s2_sew <= SEW32;
         s3_sew <= SEW32;
      end
      else
      begin
         vld_q  <= {vld_q[VALU_LATENCY-1:1], valid_i};
         s2_sew <= s1_sew;
         s3_sew <= s2_sew;
      end
   end

   valu_operand_stage u_operand (
      .clk       (clk),
      .rstn      (rstn),
      .op_i      (op_i),
      .sew_i     (sew_i),
      .opa_i     (opa_i),
      .opb_i     (opb_i),
      .op_o      (s1_op),
      .sew_o     (s1_sew),
      .opa_ext_o (s1_opa),
      .opb_ext_o (s1_opb)
   );

   valu_compare u_compare (
      .clk    (clk),
      .rstn   (rstn),
      .op_i   (s1_op),
      .opa_i  (s1_opa),
      .opb_i  (s1_opb),
      .flag_o (s3_flag)  // already two clocks late
   );

   valu_arith u_arith (
      .clk   (clk),
      .rstn  (rstn),
      .op_i  (s1_op),
      .opa_i (s1_opa),
      .opb_i (s1_opb),
      .res_o (s3_res),
      .op_o  (s3_op)
   );

   valu_result_stage u_result (
      .clk      (clk),
      .rstn     (rstn),
      .load_i   (vld_q[VALU_LATENCY-1]),  // stage 3 valid
      .op_i     (s3_op),
      .sew_i    (s3_sew),
      .res_i    (s3_res),
      .flag_i   (s3_flag),
      .result_o (result_o)
   );

   assign valid_o = vld_q[VALU_LATENCY];  // rises with the loaded result

endmodule : valu_lane

`default_nettype wire

/* bench/valu_ref_model.svh */
// expected lane results built from the opcode rules; include inside a module that imports valu_pkg
`ifndef VALU_REF_MODEL_SVH
`define VALU_REF_MODEL_SVH

function automatic int unsigned elem_width(input valu_sew_e sew);
   case (sew)
      SEW8:    return 8;
      SEW16:   return 16;
      default: return 32;  // SEW32
   endcase
endfunction

// zero-extended compares and mulhu, everything else signed
function automatic logic op_signed(input valu_op_e op);
   case (op)
      SLTU, SLEU, SGTU, SEQ, SNE, MULHU: return 1'b0;
      default:                           return 1'b1;
   endcase
endfunction

function automatic logic [VALU_XLEN-1:0] elem_extend(input logic [VALU_XLEN-1:0] v,
                                                    input int unsigned w,
                                                    input logic sgn);
   logic [VALU_XLEN-1:0] mask;  // ones over the element bits
   if (w >= VALU_XLEN)
      return v;
   mask = (32'h1 << w) - 32'h1;
   if (sgn && v[w-1])
      return v | ~mask;  // negative element
   return v & mask;
endfunction

function automatic logic [VALU_XLEN-1:0] expected_result(input valu_op_e op,
                                                        input valu_sew_e sew,
                                                        input logic [VALU_XLEN-1:0] a,
                                                        input logic [VALU_XLEN-1:0] b);
   int unsigned          w;
   logic                 sgn;
   logic [VALU_XLEN-1:0] ea;
   logic [VALU_XLEN-1:0] eb;
   logic                 lt;
   logic                 eq;
   logic [63:0]          p;   // full product
   logic [63:0]          hi;  // product moved down by the element width
   w   = elem_width(sew);
   sgn = op_signed(op);
   ea  = elem_extend(a, w, sgn);
   eb  = elem_extend(b, w, sgn);
   eq  = (ea == eb);
   lt  = sgn ? ($signed(ea) < $signed(eb)) : (ea < eb);
   if (sgn)
      p = longint'($signed(ea)) * longint'($signed(eb));
   else
      p = {32'h0, ea} * {32'h0, eb};
   hi = p >> w;
   case (op)
      ADD:         return ea + eb;
      SUB:         return ea - eb;
      AND:         return ea & eb;
      OR:          return ea | eb;
      XOR:         return ea ^ eb;
      SLT, SLTU:   return {31'b0, lt};
      SLE, SLEU:   return {31'b0, lt | eq};
      SGT, SGTU:   return {31'b0, !lt && !eq};
      SEQ:         return {31'b0, eq};
      SNE:         return {31'b0, !eq};
      MUL:         return p[31:0];
      MULH, MULHU: return hi[31:0];
      default:     return '0;
   endcase
endfunction

`endif

/* bench/valu_lane_tb.sv */
// stops at the first mismatch; random operands come from a fixed seed and sew code 3 is never driven
`timescale 1ns/10ps
`default_nettype none

module valu_lane_tb
   import valu_pkg::*;
();

   `include "valu_ref_model.svh"

   localparam int unsigned RAND_REPS = 8;   // passes over every opcode and width
   localparam int unsigned MAX_GAP   = 3;   // idle cycles between random strobes
   localparam int unsigned IDLE_PRE  = 5;   // quiet cycles before the first strobe
   localparam int unsigned NUM_OPS   = 16 * 3 * RAND_REPS + 8 * 3 * 2 + 3 * 3 * 2;
   localparam int unsigned WATCHDOG_CYCLES = NUM_OPS * (MAX_GAP + 1) + IDLE_PRE + 3
                                             + VALU_LATENCY + 20;

   logic                 clk;
   logic                 rstn;
   logic                 valid_i;
   valu_op_e             op_i;
   valu_sew_e            sew_i;
   logic [VALU_XLEN-1:0] opa_i;
   logic [VALU_XLEN-1:0] opb_i;
   logic                 valid_o;
   logic [VALU_XLEN-1:0] result_o;

   int                   seed = 32'hbbcc_3dc0;
   logic [VALU_XLEN-1:0] expect_q[$];  // results still in flight
   logic [VALU_XLEN-1:0] last_result;  // what result_o must hold between strobes
   logic [VALU_XLEN-1:0] exp_v;
   logic [VALU_LATENCY:1] strobe_hist = '0;  // bit n set when a strobe was taken n clocks ago

   valu_lane u_dut (
      .clk      (clk),
      .rstn     (rstn),
      .valid_i  (valid_i),
      .op_i     (op_i),
      .sew_i    (sew_i),
      .opa_i    (opa_i),
      .opb_i    (opb_i),
      .valid_o  (valid_o),
      .result_o (result_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns period
   end

   task automatic stop_on_error();
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp_d,
                                  input logic [31:0] got_d);
      $display("ERROR t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp_d, got_d);
      stop_on_error();
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;  // drive just after the edge
   endtask

   // one strobe, then gap idle cycles with scrambled operands
   task automatic issue_op(input valu_op_e op, input valu_sew_e sew,
                           input logic [31:0] a, input logic [31:0] b, input int unsigned gap);
      valid_i = 1'b1;
      op_i    = op;
      sew_i   = sew;
      opa_i   = a;
      opb_i   = b;
      expect_q.push_back(expected_result(op, sew, a, b));
      next_cycle();
      valid_i = 1'b0;
      opa_i   = $random(seed);  // must be ignored without valid_i
      opb_i   = $random(seed);
      repeat (gap) next_cycle();
   endtask

   always @(posedge clk)
      strobe_hist <= {strobe_hist[VALU_LATENCY-1:1], valid_i};

   // valid_o exactly four clocks after each strobe and never otherwise
   assert property (@(posedge clk) disable iff (!rstn)
                    valid_o == strobe_hist[VALU_LATENCY])
      else report_mismatch("valid_o", {31'b0, $sampled(strobe_hist[VALU_LATENCY])},
                           {31'b0, $sampled(valid_o)});

   always @(posedge clk)
   begin
      if (rstn)
      begin
         if (valid_o)
         begin
            if (expect_q.size() == 0)
            begin
               $display("valid_o high at t=%0t with no operation outstanding", $time);
               stop_on_error();
            end
            else
            begin
               exp_v = expect_q.pop_front();
               assert (result_o == exp_v) else report_mismatch("result_o", exp_v, result_o);
               last_result = exp_v;
            end
         end
         else
            assert (result_o == last_result)  // zero before the first result, held later
               else report_mismatch("result_o", last_result, result_o);
      end
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog timed out after %0d cycles with results still missing",
               WATCHDOG_CYCLES);
      stop_on_error();
   end

   initial
   begin
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      logic [31:0] sbit;  // sign bit of the element
      valid_i     = 1'b0;
      op_i        = ADD;
      sew_i       = SEW32;
      opa_i       = '0;
      opb_i       = '0;
      rstn        = 1'b0;
      last_result = '0;
      repeat (3) @(posedge clk);
      #1;
      rstn = 1'b1;
      repeat (IDLE_PRE) next_cycle();  // output must stay quiet and zero
      for (int s = 0; s < 3; s++)
      begin
         sbit = 32'h1 << (elem_width(valu_sew_e'(s)) - 1);
         for (int o = int'(SLT); o <= int'(SNE); o++)
         begin
            a = $random(seed);
            issue_op(valu_op_e'(o), valu_sew_e'(s), a, a, 0);          // equal operands
            issue_op(valu_op_e'(o), valu_sew_e'(s), a, a ^ sbit, 1);   // sign bit only
         end
         for (int o = int'(MUL); o <= int'(MULHU); o++)
         begin
            issue_op(valu_op_e'(o), valu_sew_e'(s), '1, '1, 0);        // minus one squared
            issue_op(valu_op_e'(o), valu_sew_e'(s), sbit, sbit, 0);    // most negative
         end
      end
      for (int k = 0; k < RAND_REPS; k++)
         for (int s = 0; s < 3; s++)
            for (int o = 0; o < 16; o++)
            begin
               a = $random(seed);
               b = $random(seed);
               r = $random(seed);
               issue_op(valu_op_e'(o), valu_sew_e'(s), a, b, r[0] ? 0 : r[2:1]);
            end
      while (expect_q.size() != 0)
         next_cycle();
      repeat (VALU_LATENCY + 2) next_cycle();  // no late strobe may follow
      $display("NO ERRORS");
      $finish;
   end

endmodule : valu_lane_tb

`default_nettype wire

/* build.f */
+incdir+bench
common/valu_pkg.sv
rtl/valu_operand_stage.sv
rtl/valu_compare.sv
rtl/valu_arith.sv
rtl/valu_result_stage.sv
rtl/valu_lane.sv
bench/valu_lane_tb.sv

/* Bender.yml */
package:
  name: valu_lane

sources:
  - files:
      - common/valu_pkg.sv
      - rtl/valu_operand_stage.sv
      - rtl/valu_compare.sv
      - rtl/valu_arith.sv
      - rtl/valu_result_stage.sv
      - rtl/valu_lane.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/valu_lane_tb.sv
